/* tlb_mmu.f */
logic/tlb_pkg.sv
logic/tlb_op_ctrl.sv
logic/tlb_fill_counter.sv
logic/tlb_entries.sv
logic/tlb_lookup.sv
logic/tlb_search.sv
logic/tlb_top.sv
tests/tlb_clk_gen.sv
tests/tlb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tlb_tb -f tlb_mmu.f -o tlb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tlb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

/* tests/tlb_tb.sv */
module tlb_tb import tlb_pkg::*; ();

    typedef struct packed {
        logic          lookup;
        logic          cmp_only;
        logic          do_flush;
        tlb_op_t       op;
        tlb_index_t    index;
        tlb_cmp_t      cmp;
        tlb_trans_t    even;
        tlb_trans_t    odd;
        tlb_invld_op_t invld_op;
        tlb_asid_t     asid;
        tlb_vppn_t     vppn;
        tlb_va_t       va;
        logic [3:0]    stall_cycles;
        logic          exp_hit;
        tlb_index_t    exp_index;
        tlb_pa_t       exp_pa;
        tlb_trans_t    exp_page;
    } step_t;

    localparam tlb_vppn_t V3 = 19'h12345;
    localparam tlb_vppn_t V4 = {10'h350, 9'h000};
    localparam tlb_vppn_t V5 = 19'h00777;
    localparam tlb_vppn_t F0 = 19'h01000;
    localparam tlb_vppn_t F1 = 19'h01001;

    logic          clk;
    logic          rstn;
    logic          flush;
    tlb_asid_t     asid;
    logic          req;
    logic          stall;
    tlb_va_t       va;
    tlb_op_t       op;
    tlb_index_t    wr_index;
    tlb_cmp_t      wr_cmp;
    tlb_trans_t    wr_even;
    tlb_trans_t    wr_odd;
    tlb_invld_op_t invld_op;
    tlb_asid_t     invld_asid;
    tlb_vppn_t     invld_vppn;
    tlb_vppn_t     srch_vppn;
    tlb_index_t    rd_index;
    logic          resp_valid;
    logic          hit;
    tlb_pa_t       pa;
    logic          page_valid;
    logic          dirty;
    logic          cached;
    logic [1:0]    plv;
    logic          op_done;
    logic          srch_hit;
    tlb_index_t    srch_index;
    tlb_cmp_t      rd_cmp;
    tlb_trans_t    rd_even;
    tlb_trans_t    rd_odd;

    step_t steps[$];
    string names[$];
    int    n_rows = 0;
    int    checks = 0;
    int    errors = 0;
    int    tests = 0;
    int    failed_tests = 0;

    tlb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    tlb_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .asid       (asid),
        .req        (req),
        .stall      (stall),
        .va         (va),
        .op         (op),
        .wr_index   (wr_index),
        .wr_cmp     (wr_cmp),
        .wr_even    (wr_even),
        .wr_odd     (wr_odd),
        .invld_op   (invld_op),
        .invld_asid (invld_asid),
        .invld_vppn (invld_vppn),
        .srch_vppn  (srch_vppn),
        .rd_index   (rd_index),
        .resp_valid (resp_valid),
        .hit        (hit),
        .pa         (pa),
        .page_valid (page_valid),
        .dirty      (dirty),
        .cached     (cached),
        .plv        (plv),
        .op_done    (op_done),
        .srch_hit   (srch_hit),
        .srch_index (srch_index),
        .rd_cmp     (rd_cmp),
        .rd_even    (rd_even),
        .rd_odd     (rd_odd)
    );

    task automatic check_bit(string name, string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: %s expected %b, actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_pa(string name, tlb_pa_t exp, tlb_pa_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: pa expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_plv(string name, logic [1:0] exp, logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: plv expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_index(string name, tlb_index_t exp, tlb_index_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: index expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_cmp(string name, tlb_cmp_t exp, tlb_cmp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: compare part expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_trans(string name, string what, tlb_trans_t exp, tlb_trans_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: %s page expected %h, actual %h", name, what, exp, act);
        end
    endtask

    function automatic step_t access_row(tlb_op_t code, tlb_index_t index, tlb_cmp_t cmp,
                                         tlb_trans_t even, tlb_trans_t odd);
        step_t s;
        s       = '0;
        s.op    = code;
        s.index = index;
        s.cmp   = cmp;
        s.even  = even;
        s.odd   = odd;
        return s;
    endfunction

    function automatic step_t search_row(tlb_asid_t id, tlb_vppn_t vppn, logic exp_hit,
                                         tlb_index_t exp_index);
        step_t s;
        s           = '0;
        s.op        = OP_SRCH;
        s.asid      = id;
        s.vppn      = vppn;
        s.exp_hit   = exp_hit;
        s.exp_index = exp_index;
        return s;
    endfunction

    function automatic step_t invalidate_row(tlb_invld_op_t code, tlb_asid_t id,
                                             tlb_vppn_t vppn);
        step_t s;
        s          = '0;
        s.op       = OP_INVLD;
        s.invld_op = code;
        s.asid     = id;
        s.vppn     = vppn;
        return s;
    endfunction

    function automatic step_t lookup_row(tlb_asid_t id, tlb_va_t addr, logic [3:0] stalls,
                                         logic exp_hit, tlb_pa_t exp_pa, tlb_trans_t exp_page);
        step_t s;
        s              = '0;
        s.lookup       = 1'b1;
        s.asid         = id;
        s.va           = addr;
        s.stall_cycles = stalls;
        s.exp_hit      = exp_hit;
        s.exp_pa       = exp_pa;
        s.exp_page     = exp_page;
        return s;
    endfunction

    task automatic add_row(string name, step_t s);
        names.push_back(name);
        steps.push_back(s);
    endtask

    task automatic apply_inputs(step_t s);
        asid       = s.asid;
        va         = s.va;
        wr_index   = s.index;
        rd_index   = s.index;
        wr_cmp     = s.cmp;
        wr_even    = s.even;
        wr_odd     = s.odd;
        invld_op   = s.invld_op;
        invld_asid = s.asid;
        invld_vppn = s.vppn;
        srch_vppn  = s.vppn;
    endtask

    task automatic run_op(string name, step_t s);
        int wait_cycles;
        @(negedge clk);
        apply_inputs(s);
        op = s.op;
        @(negedge clk);
        op = OP_NONE;
        wait_cycles = 0;
        while (!op_done && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!op_done) begin
            errors++;
            $display("%s: op_done did not rise within 10 cycles", name);
        end else if (s.op == OP_RD) begin
            check_cmp(name, s.cmp, rd_cmp);
            if (!s.cmp_only) begin
                check_trans(name, "even", s.even, rd_even);
                check_trans(name, "odd", s.odd, rd_odd);
            end
        end else if (s.op == OP_SRCH) begin
            check_bit(name, "srch_hit", s.exp_hit, srch_hit);
            check_index(name, s.exp_index, srch_index);
        end
    endtask

    task automatic run_lookup(string name, step_t s);
        @(negedge clk);
        apply_inputs(s);
        req = 1'b1;
        @(negedge clk);
        req = 1'b0;
        flush = s.do_flush;
        if (s.stall_cycles != 4'd0) begin
            stall = 1'b1;
            repeat (s.stall_cycles) begin
                @(negedge clk);
                check_bit(name, "resp_valid during stall", 1'b0, resp_valid);
            end
            stall = 1'b0;
        end
        @(negedge clk);
        flush = 1'b0;
        check_bit(name, "resp_valid", !s.do_flush, resp_valid);
        check_bit(name, "hit", s.exp_hit, hit);
        check_pa(name, s.exp_pa, pa);
        check_bit(name, "page_valid", s.exp_page.v, page_valid);
        check_bit(name, "dirty", s.exp_page.d, dirty);
        check_bit(name, "cached", s.exp_page.mat == MAT_CACHED, cached);
        check_plv(name, s.exp_page.plv, plv);
    endtask

    initial begin
        tlb_cmp_t   e3_cmp;
        tlb_cmp_t   e4_cmp;
        tlb_cmp_t   e5_cmp;
        tlb_cmp_t   f0_cmp;
        tlb_cmp_t   f1_cmp;
        tlb_trans_t pg_a;
        tlb_trans_t pg_b;
        tlb_trans_t pg_c;
        tlb_trans_t pg_d;
        tlb_va_t    va_e;
        tlb_va_t    va_o;
        tlb_va_t    va_m;
        tlb_va_t    va_m2;
        logic [31:0] rnd;
        step_t      s;
        int         errors_before;

        flush      = 1'b0;
        asid       = '0;
        req        = 1'b0;
        stall      = 1'b0;
        va         = '0;
        op         = OP_NONE;
        wr_index   = '0;
        wr_cmp     = '0;
        wr_even    = '0;
        wr_odd     = '0;
        invld_op   = '0;
        invld_asid = '0;
        invld_vppn = '0;
        srch_vppn  = '0;
        rd_index   = '0;

        void'($urandom(80759));
        e3_cmp = '{e: 1'b1, asid: 10'd5, g: 1'b0, ps: PS_4K, vppn: V3};
        e4_cmp = '{e: 1'b1, asid: 10'd2, g: 1'b1, ps: PS_4M, vppn: V4};
        e5_cmp = '{e: 1'b1, asid: 10'd5, g: 1'b0, ps: PS_4K, vppn: V5};
        f0_cmp = '{e: 1'b1, asid: 10'd7, g: 1'b1, ps: PS_4K, vppn: F0};
        f1_cmp = '{e: 1'b1, asid: 10'd7, g: 1'b0, ps: PS_4K, vppn: F1};
        pg_a   = '{v: 1'b1, d: 1'b0, mat: 2'd1, plv: 2'd0, ppn: 20'habcde};
        pg_b   = '{v: 1'b1, d: 1'b1, mat: 2'd0, plv: 2'd3, ppn: 20'h13579};
        pg_c   = '{v: 1'b0, d: 1'b1, mat: 2'd2, plv: 2'd1, ppn: 20'h80400};
        pg_d   = '{v: 1'b1, d: 1'b1, mat: 2'd1, plv: 2'd2, ppn: 20'h2468a};

        // Random page offsets, page-select bit fixed per case
        rnd   = $urandom();
        va_e  = {V3, 1'b0, rnd[11:0]};
        rnd   = $urandom();
        va_o  = {V3, 1'b1, rnd[11:0]};
        rnd   = $urandom();
        va_m  = {V4[18:9], 1'b1, rnd[20:0]};
        rnd   = $urandom();
        va_m2 = {V4[18:9], 1'b0, rnd[20:0]};

        s = access_row(OP_RD, 5'd7, '0, '0, '0);
        s.cmp_only = 1'b1;
        add_row("read_after_reset", s);
        add_row("write_4k_idx3", access_row(OP_WR, 5'd3, e3_cmp, pg_a, pg_b));
        add_row("read_idx3", access_row(OP_RD, 5'd3, e3_cmp, pg_a, pg_b));
        add_row("write_4m_idx4", access_row(OP_WR, 5'd4, e4_cmp, pg_c, pg_d));
        add_row("write_4k_idx5", access_row(OP_WR, 5'd5, e5_cmp, pg_b, pg_a));
        add_row("write_dup_idx9", access_row(OP_WR, 5'd9, e3_cmp, pg_c, pg_c));
        add_row("lookup_4k_even",
                lookup_row(10'd5, va_e, 4'd0, 1'b1, {pg_a.ppn, va_e[11:0]}, pg_a));
        add_row("lookup_4k_odd",
                lookup_row(10'd5, va_o, 4'd0, 1'b1, {pg_b.ppn, va_o[11:0]}, pg_b));
        add_row("lookup_4m_stall",
                lookup_row(10'd5, va_m, 4'd3, 1'b1, {pg_d.ppn[19:9], va_m[20:0]}, pg_d));
        add_row("lookup_asid_miss", lookup_row(10'd6, va_e, 4'd0, 1'b0, '0, '0));
        add_row("lookup_global_hit",
                lookup_row(10'd6, va_m2, 4'd0, 1'b1, {pg_c.ppn[19:9], va_m2[20:0]}, pg_c));
        // A hitting lookup that is flushed in flight gives nothing
        s = lookup_row(10'd5, va_e, 4'd0, 1'b0, '0, '0);
        s.do_flush = 1'b1;
        add_row("lookup_flush", s);
        add_row("fill_first", access_row(OP_FILL, 5'd20, f0_cmp, pg_d, pg_a));
        add_row("fill_second", access_row(OP_FILL, 5'd20, f1_cmp, pg_b, pg_c));
        add_row("read_fill_idx0", access_row(OP_RD, 5'd0, f0_cmp, pg_d, pg_a));
        add_row("read_fill_idx1", access_row(OP_RD, 5'd1, f1_cmp, pg_b, pg_c));
        add_row("search_lowest_index", search_row(10'd5, V3, 1'b1, 5'd3));
        add_row("invalidate_g_set", invalidate_row(5'd2, 10'd0, '0));
        add_row("search_fill0_gone", search_row(10'd7, F0, 1'b0, 5'd0));
        add_row("search_4m_gone", search_row(10'd2, V4, 1'b0, 5'd0));
        add_row("search_idx3_kept", search_row(10'd5, V3, 1'b1, 5'd3));
        add_row("invalidate_asid", invalidate_row(5'd4, 10'd7, '0));
        add_row("search_fill1_gone", search_row(10'd7, F1, 1'b0, 5'd0));
        add_row("search_idx5_kept", search_row(10'd5, V5, 1'b1, 5'd5));
        add_row("invalidate_asid_vppn", invalidate_row(5'd6, 10'd5, V5));
        add_row("search_idx5_gone", search_row(10'd5, V5, 1'b0, 5'd0));
        add_row("search_idx3_still", search_row(10'd5, V3, 1'b1, 5'd3));
        n_rows = steps.size();

        wait (rstn === 1'b1);
        @(negedge clk);
        errors_before = errors;
        check_bit("reset_state", "resp_valid", 1'b0, resp_valid);
        check_bit("reset_state", "op_done", 1'b0, op_done);
        check_bit("reset_state", "srch_hit", 1'b0, srch_hit);
        tests++;
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("%-22s %s", "reset_state", (errors == errors_before) ? "ok" : "mismatch");

        for (int i = 0; i < n_rows; i++) begin
            errors_before = errors;
            s = steps[i];
            if (s.lookup) begin
                run_lookup(names[i], s);
            end else begin
                run_op(names[i], s);
            end
            tests++;
            if (errors != errors_before) begin
                failed_tests++;
            end
            $display("%-22s %s", names[i], (errors == errors_before) ? "ok" : "mismatch");
        end

        $display("Tests: %0d, failed tests: %0d, checks: %0d, errors: %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Budget of 12 cycles per row plus reset
    initial begin
        int limit;
        wait (n_rows > 0);
        limit = (n_rows * 12 + 10) * 40;
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tests/tlb_clk_gen.sv */
module tlb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held for four rising edges, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

/* logic/tlb_top.sv */
module tlb_top import tlb_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  logic          flush,
    input  tlb_asid_t     asid,
    input  logic          req,
    input  logic          stall,
    input  tlb_va_t       va,
    input  tlb_op_t       op,
    input  tlb_index_t    wr_index,
    input  tlb_cmp_t      wr_cmp,
    input  tlb_trans_t    wr_even,
    input  tlb_trans_t    wr_odd,
    input  tlb_invld_op_t invld_op,
    input  tlb_asid_t     invld_asid,
    input  tlb_vppn_t     invld_vppn,
    input  tlb_vppn_t     srch_vppn,
    input  tlb_index_t    rd_index,
    output logic          resp_valid,
    output logic          hit,
    output tlb_pa_t       pa,
    output logic          page_valid,
    output logic          dirty,
    output logic          cached,
    output logic [1:0]    plv,
    output logic          op_done,
    output logic          srch_hit,
    output tlb_index_t    srch_index,
    output tlb_cmp_t      rd_cmp,
    output tlb_trans_t    rd_even,
    output tlb_trans_t    rd_odd
);

    logic       wr_en;
    logic       fill_sel;
    logic       fill_adv;
    logic       invld_en;
    logic       srch_en;
    logic       rd_en;
    tlb_index_t fill_index;

    tlb_cmp_t   cmp_arr [TLB_NUM];
    tlb_trans_t even_arr [TLB_NUM];
    tlb_trans_t odd_arr [TLB_NUM];

    tlb_op_ctrl u_op_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .op       (op),
        .wr_en    (wr_en),
        .fill_sel (fill_sel),
        .fill_adv (fill_adv),
        .invld_en (invld_en),
        .srch_en  (srch_en),
        .rd_en    (rd_en),
        .op_done  (op_done)
    );

    tlb_fill_counter u_fill_counter (
        .clk        (clk),
        .rstn       (rstn),
        .fill_adv   (fill_adv),
        .fill_index (fill_index)
    );

    tlb_entries u_entries (
        .clk        (clk),
        .rstn       (rstn),
        .wr_en      (wr_en),
        .fill_sel   (fill_sel),
        .wr_index   (wr_index),
        .fill_index (fill_index),
        .wr_cmp     (wr_cmp),
        .wr_even    (wr_even),
        .wr_odd     (wr_odd),
        .invld_en   (invld_en),
        .invld_op   (invld_op),
        .invld_asid (invld_asid),
        .invld_vppn (invld_vppn),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .cmp_arr    (cmp_arr),
        .even_arr   (even_arr),
        .odd_arr    (odd_arr),
        .rd_cmp     (rd_cmp),
        .rd_even    (rd_even),
        .rd_odd     (rd_odd)
    );

    tlb_lookup u_lookup (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .asid       (asid),
        .req        (req),
        .stall      (stall),
        .va         (va),
        .cmp_arr    (cmp_arr),
        .even_arr   (even_arr),
        .odd_arr    (odd_arr),
        .resp_valid (resp_valid),
        .hit        (hit),
        .pa         (pa),
        .page_valid (page_valid),
        .dirty      (dirty),
        .cached     (cached),
        .plv        (plv)
    );

    tlb_search u_search (
        .clk        (clk),
        .rstn       (rstn),
        .srch_en    (srch_en),
        .asid       (asid),
        .srch_vppn  (srch_vppn),
        .cmp_arr    (cmp_arr),
        .srch_hit   (srch_hit),
        .srch_index (srch_index)
    );

endmodule

/* logic/tlb_search.sv */
module tlb_search import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       srch_en,
    input  tlb_asid_t  asid,
    input  tlb_vppn_t  srch_vppn,
    input  tlb_cmp_t   cmp_arr [TLB_NUM],
    output logic       srch_hit,
    output tlb_index_t srch_index
);

    logic [TLB_NUM-1:0] hit_vec;
    tlb_index_t         first_index;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_hit
        assign hit_vec[i] = cmp_arr[i].e
            && (cmp_arr[i].g || cmp_arr[i].asid == asid)
            && cmp_arr[i].vppn == srch_vppn;
    end

    // Priority encoder, index 0 when nothing hits
    always_comb begin
        first_index = '0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                first_index = tlb_index_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            srch_hit   <= 1'b0;
            srch_index <= '0;
        end else if (srch_en) begin
            srch_hit   <= |hit_vec;
            srch_index <= first_index;
        end
    end

endmodule

/* logic/tlb_lookup.sv */
module tlb_lookup import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       flush,
    input  tlb_asid_t  asid,
    input  logic       req,
    input  logic       stall,
    input  tlb_va_t    va,
    input  tlb_cmp_t   cmp_arr [TLB_NUM],
    input  tlb_trans_t even_arr [TLB_NUM],
    input  tlb_trans_t odd_arr [TLB_NUM],
    output logic       resp_valid,
    output logic       hit,
    output tlb_pa_t    pa,
    output logic       page_valid,
    output logic       dirty,
    output logic       cached,
    output logic [1:0] plv
);

    logic [TLB_NUM-1:0] is_4k;
    logic [TLB_NUM-1:0] match;
    tlb_trans_t         sel_trans;
    logic               sel_4k;

    logic               s1_valid;
    tlb_va_t            s1_va;
    logic [TLB_NUM-1:0] s1_match;
    tlb_trans_t         s1_trans;
    logic               s1_4k;
    logic               s1_hit;
    tlb_pa_t            pa_nxt;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_match
        assign is_4k[i] = cmp_arr[i].ps == PS_4K;
        // Large pages compare only the upper ten VPPN bits
        assign match[i] = cmp_arr[i].e
            && (cmp_arr[i].g || cmp_arr[i].asid == asid)
            && (is_4k[i] ? cmp_arr[i].vppn == va[31:13]
                         : cmp_arr[i].vppn[18:9] == va[31:22]);
    end

    // Lowest matching index wins
    always_comb begin
        sel_trans = '0;
        sel_4k    = 1'b0;
        for (int i = TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_4k = is_4k[i];
                if (is_4k[i] ? va[12] : va[21]) begin
                    sel_trans = odd_arr[i];
                end else begin
                    sel_trans = even_arr[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s1_va    <= '0;
            s1_match <= '0;
            s1_trans <= '0;
            s1_4k    <= 1'b0;
        end else if (flush) begin
            s1_valid <= 1'b0;
            s1_va    <= '0;
            s1_match <= '0;
            s1_trans <= '0;
            s1_4k    <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req;
            s1_va    <= va;
            s1_match <= req ? match : '0;
            s1_trans <= req ? sel_trans : '0;
            s1_4k    <= sel_4k;
        end
    end

    assign s1_hit = |s1_match;
    assign pa_nxt = s1_4k ? {s1_trans.ppn, s1_va[11:0]}
                          : {s1_trans.ppn[19:9], s1_va[20:0]};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            resp_valid <= 1'b0;
            hit        <= 1'b0;
            pa         <= '0;
            page_valid <= 1'b0;
            dirty      <= 1'b0;
            cached     <= 1'b0;
            plv        <= '0;
        end else if (flush) begin
            resp_valid <= 1'b0;
            hit        <= 1'b0;
            pa         <= '0;
            page_valid <= 1'b0;
            dirty      <= 1'b0;
            cached     <= 1'b0;
            plv        <= '0;
        end else if (!stall) begin
            resp_valid <= s1_valid;
            hit        <= s1_hit;
            pa         <= s1_hit ? pa_nxt : '0;
            page_valid <= s1_hit && s1_trans.v;
            dirty      <= s1_hit && s1_trans.d;
            cached     <= s1_hit && s1_trans.mat == MAT_CACHED;
            plv        <= s1_hit ? s1_trans.plv : 2'b00;
        end
    end

endmodule

/* logic/tlb_entries.sv */
module tlb_entries import tlb_pkg::*; (
    input  logic          clk,
    input  logic          rstn,
    input  logic          wr_en,
    input  logic          fill_sel,
    input  tlb_index_t    wr_index,
    input  tlb_index_t    fill_index,
    input  tlb_cmp_t      wr_cmp,
    input  tlb_trans_t    wr_even,
    input  tlb_trans_t    wr_odd,
    input  logic          invld_en,
    input  tlb_invld_op_t invld_op,
    input  tlb_asid_t     invld_asid,
    input  tlb_vppn_t     invld_vppn,
    input  logic          rd_en,
    input  tlb_index_t    rd_index,
    output tlb_cmp_t      cmp_arr [TLB_NUM],
    output tlb_trans_t    even_arr [TLB_NUM],
    output tlb_trans_t    odd_arr [TLB_NUM],
    output tlb_cmp_t      rd_cmp,
    output tlb_trans_t    rd_even,
    output tlb_trans_t    rd_odd
);

    tlb_index_t         wr_sel;
    logic [TLB_NUM-1:0] asid_eq;
    logic [TLB_NUM-1:0] vppn_eq;
    logic [TLB_NUM-1:0] invld_hit;

    assign wr_sel = fill_sel ? fill_index : wr_index;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_cmp
        assign asid_eq[i] = cmp_arr[i].asid == invld_asid;
        assign vppn_eq[i] = cmp_arr[i].vppn == invld_vppn;
    end

    // Entries hit by the invalidate code
    always_comb begin
        for (int i = 0; i < TLB_NUM; i++) begin
            case (invld_op)
                5'd0, 5'd1: invld_hit[i] = 1'b1;
                5'd2:       invld_hit[i] = cmp_arr[i].g;
                5'd3:       invld_hit[i] = !cmp_arr[i].g;
                5'd4:       invld_hit[i] = !cmp_arr[i].g && asid_eq[i];
                5'd5:       invld_hit[i] = !cmp_arr[i].g && asid_eq[i] && vppn_eq[i];
                5'd6:       invld_hit[i] = (cmp_arr[i].g || asid_eq[i]) && vppn_eq[i];
                default:    invld_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                cmp_arr[i]  <= '0;
                even_arr[i] <= '0;
                odd_arr[i]  <= '0;
            end
        end else if (wr_en) begin
            cmp_arr[wr_sel]  <= wr_cmp;
            even_arr[wr_sel] <= wr_even;
            odd_arr[wr_sel]  <= wr_odd;
        end else if (invld_en) begin
            for (int i = 0; i < TLB_NUM; i++) begin
                if (invld_hit[i]) begin
                    cmp_arr[i].e <= 1'b0;
                end
            end
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_cmp  <= cmp_arr[rd_index];
            rd_even <= even_arr[rd_index];
            rd_odd  <= odd_arr[rd_index];
        end
    end

endmodule

/* logic/tlb_fill_counter.sv */
module tlb_fill_counter import tlb_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       fill_adv,
    output tlb_index_t fill_index
);

    // Moves on only after the fill has used the current slot
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fill_index <= '0;
        end else if (fill_adv) begin
            if (fill_index == tlb_index_t'(TLB_NUM - 1)) begin
                fill_index <= '0;
            end else begin
                fill_index <= fill_index + 1'b1;
            end
        end
    end

endmodule

/* logic/tlb_op_ctrl.sv */
module tlb_op_ctrl import tlb_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  tlb_op_t op,
    output logic    wr_en,
    output logic    fill_sel,
    output logic    fill_adv,
    output logic    invld_en,
    output logic    srch_en,
    output logic    rd_en,
    output logic    op_done
);

    typedef enum logic {
        ST_IDLE,
        ST_DONE
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (op != OP_NONE) begin
                    state_nxt = ST_DONE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Ops arriving outside IDLE are dropped
    always_comb begin
        wr_en    = 1'b0;
        fill_sel = 1'b0;
        fill_adv = 1'b0;
        invld_en = 1'b0;
        srch_en  = 1'b0;
        rd_en    = 1'b0;
        if (state == ST_IDLE) begin
            case (op)
                OP_SRCH:  srch_en = 1'b1;
                OP_RD:    rd_en = 1'b1;
                OP_WR:    wr_en = 1'b1;
                OP_FILL: begin
                    wr_en    = 1'b1;
                    fill_sel = 1'b1;
                    fill_adv = 1'b1;
                end
                OP_INVLD: invld_en = 1'b1;
                default:  ;
            endcase
        end
    end

    assign op_done = state == ST_DONE;

endmodule

/* logic/tlb_pkg.sv */
package tlb_pkg;

    localparam int TLB_NUM     = 32;
    localparam int TLB_INDEX_W = 5;

    // Page size codes as held in the PS field
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_4M = 6'd21;

    localparam logic [1:0] MAT_CACHED = 2'd1;

    typedef logic [TLB_INDEX_W-1:0] tlb_index_t;
    typedef logic [9:0]             tlb_asid_t;
    typedef logic [18:0]            tlb_vppn_t;
    typedef logic [31:0]            tlb_va_t;
    typedef logic [31:0]            tlb_pa_t;
    typedef logic [4:0]             tlb_invld_op_t;

    typedef struct packed {
        logic       e;
        tlb_asid_t  asid;
        logic       g;
        logic [5:0] ps;
        tlb_vppn_t  vppn;
    } tlb_cmp_t;

    // One page of the even/odd pair
    typedef struct packed {
        logic        v;
        logic        d;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic [19:0] ppn;
    } tlb_trans_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_SRCH,
        OP_RD,
        OP_WR,
        OP_FILL,
        OP_INVLD
    } tlb_op_t;

endpackage
